/* include/reg_bus_macros.svh */
// register bus constants: widths, address spaces, board register offsets and fixed values
`ifndef REG_BUS_MACROS_SVH
`define REG_BUS_MACROS_SVH

// ----------------------------------------
// bus widths
// ----------------------------------------
`define REG_ADDR_W      16              // register address, quadlet granular
`define REG_DATA_W      32              // one quadlet

// ----------------------------------------
// address map, space code in addr[15:12]
// ----------------------------------------
`define SPACE_MAIN      4'h0            // board registers
`define SPACE_HUB       4'h2            // hub memory

// board register offsets in addr[3:0]
`define REG_STATUS      4'd0
`define REG_FW_VERSION  4'd4
`define REG_IPADDR      4'd11

// fixed values
`define IPADDR_RESET    32'hFFFF_FFFF   // unassigned address
`define FW_VERSION      32'h0007_0200
`define STATUS_MAGIC    16'h5146        // upper half of status

`endif

/* hdl/reg_bus_pkg.sv */
// register bus types shared by the hosts, the arbiter and the targets
`include "reg_bus_macros.svh"

package reg_bus_pkg;

    // ----------------------------------------
    // bus payload
    // ----------------------------------------
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;     // quadlet address
    typedef logic [`REG_DATA_W-1:0] reg_data_t;     // quadlet data

    // ----------------------------------------
    // address space, taken from addr[15:12]
    // ----------------------------------------
    typedef enum logic [3:0] {
        ADDR_MAIN = `SPACE_MAIN,                    // board registers, no wait
        ADDR_HUB  = `SPACE_HUB                      // hub memory, one wait cycle
    } addr_space_t;

endpackage

/* hdl/host_pkg.sv */
// host side types: which host owns a bus and the state of a host port

package host_pkg;

    typedef enum logic {
        HOST_FW  = 1'b0,        // FireWire, wins ties
        HOST_ETH = 1'b1         // Ethernet
    } host_id_t;

    typedef enum logic [1:0] {
        ST_IDLE,                // waiting for req
        ST_WAIT_GRANT,          // bus requested, not yet owned
        ST_ACCESS,              // owns the bus, waiting for rvalid or issuing wen
        ST_ACK                  // ack high until host drops req
    } host_state_t;

endpackage

/* hdl/host_port.sv */
// host port that turns a four-phase req/ack transaction into one register bus access
`timescale 1ns/1ps
module host_port
    import reg_bus_pkg::*;
    import host_pkg::*;
(
    input  logic      sysclk,
    input  logic      rst_n,
    // host handshake
    input  logic      req,          // host request, held until ack
    input  logic      we,           // 1 -> write, 0 -> read
    input  reg_addr_t addr,
    input  reg_data_t wdata,
    output logic      ack,
    output reg_data_t rdata,        // valid while ack is high on a read
    // register bus
    output logic      req_read,
    output logic      req_write,
    input  logic      grant_read,
    input  logic      grant_write,
    output reg_addr_t raddr,
    output reg_addr_t waddr,
    output reg_data_t wdata_bus,
    output logic      wen,
    input  reg_data_t reg_rdata,
    input  logic      reg_rvalid
);

    host_state_t state;
    reg_addr_t   addr_q;            // captured at req
    reg_data_t   wdata_q;
    logic        we_q;
    logic        busy;              // bus request outstanding
    logic        rd_done;           // read data accepted this cycle

    // ----------------------------------------
    // bus side outputs
    // ----------------------------------------
    assign busy      = (state == ST_WAIT_GRANT) || (state == ST_ACCESS);
    assign req_read  = busy && !we_q;
    assign req_write = busy && we_q;
    assign raddr     = addr_q;
    assign waddr     = addr_q;
    assign wdata_bus = wdata_q;

    // read data counts only while we own the read bus since the mux may show the other host
    assign rd_done = (state == ST_ACCESS) && !we_q && grant_read && reg_rvalid;

    // single write pulse issued only while the write grant is still ours
    assign wen = (state == ST_ACCESS) && we_q && grant_write;

    assign ack = (state == ST_ACK);

    // ----------------------------------------
    // handshake FSM
    // ----------------------------------------
    always_ff @(posedge sysclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= ST_IDLE;
        end
        else
        begin
            case (state)
                ST_IDLE:
                    if (req)
                        state <= ST_WAIT_GRANT;                 // ack is low here
                ST_WAIT_GRANT:
                    if (we_q ? grant_write : grant_read)
                        state <= ST_ACCESS;                     // grant lags request a cycle
                ST_ACCESS:
                    if (rd_done || wen)
                        state <= ST_ACK;                        // ack rises next cycle
                ST_ACK:
                    if (!req)
                        state <= ST_IDLE;                       // ack drops a cycle after req
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    // payload capture
    always_ff @(posedge sysclk)
    begin
        if ((state == ST_IDLE) && req)
        begin
            addr_q  <= addr;
            wdata_q <= wdata;
            we_q    <= we;
        end
        if (rd_done)
            rdata <= reg_rdata;                                 // held through the ack phase
    end

endmodule

/* hdl/bus_arbiter.sv */
// read and write bus arbitration between FireWire and Ethernet, plus the shared bus muxes
`timescale 1ns/1ps
module bus_arbiter
    import reg_bus_pkg::*;
    import host_pkg::*;
(
    input  logic      sysclk,
    input  logic      rst_n,
    input  logic      fw_req_read,
    input  logic      eth_req_read,
    input  logic      fw_req_write,
    input  logic      eth_req_write,
    output logic      fw_grant_read,
    output logic      eth_grant_read,
    output logic      fw_grant_write,
    output logic      eth_grant_write,
    input  reg_addr_t fw_raddr,
    input  reg_addr_t eth_raddr,
    input  reg_addr_t fw_waddr,
    input  reg_addr_t eth_waddr,
    input  reg_data_t fw_wdata,
    input  reg_data_t eth_wdata,
    input  logic      fw_wen,
    input  logic      eth_wen,
    output reg_addr_t reg_raddr,
    output reg_addr_t reg_waddr,
    output reg_data_t reg_wdata,
    output logic      reg_wen
);

    host_id_t rd_owner;     // current read bus owner
    host_id_t wr_owner;     // current write bus owner

    // ----------------------------------------
    // grants with FireWire on request or when idle
    // ----------------------------------------
    always_ff @(posedge sysclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            fw_grant_read   <= 1'b1;                            // FireWire parks on the bus
            eth_grant_read  <= 1'b0;
            fw_grant_write  <= 1'b1;
            eth_grant_write <= 1'b0;
        end
        else
        begin
            fw_grant_read   <= fw_req_read | ~eth_req_read;
            eth_grant_read  <= eth_req_read & ~fw_req_read;
            fw_grant_write  <= fw_req_write | ~eth_req_write;
            eth_grant_write <= eth_req_write & ~fw_req_write;
        end
    end

    assign rd_owner = eth_grant_read ? HOST_ETH : HOST_FW;
    assign wr_owner = eth_grant_write ? HOST_ETH : HOST_FW;

    // ----------------------------------------
    // shared bus muxes
    // ----------------------------------------
    assign reg_raddr = (rd_owner == HOST_ETH) ? eth_raddr : fw_raddr;

    always_comb
    begin
        case (wr_owner)
            HOST_ETH:
            begin
                reg_waddr = eth_waddr;
                reg_wdata = eth_wdata;
                reg_wen   = eth_wen;
            end
            default:
            begin
                reg_waddr = fw_waddr;
                reg_wdata = fw_wdata;
                reg_wen   = fw_wen;                             // low after reset while port idles
            end
        endcase
    end

endmodule

/* hdl/read_path.sv */
// read data routing by address space, with the wait flag and the derived read valid
`timescale 1ns/1ps
module read_path
    import reg_bus_pkg::*;
(
    input  logic      sysclk,
    input  logic      rst_n,
    input  reg_addr_t reg_raddr,
    input  reg_data_t rdata_regs,       // board registers in the same cycle
    input  reg_data_t rdata_hub,        // hub memory one cycle late
    output reg_data_t reg_rdata,
    output logic      reg_rvalid
);

    addr_space_t space;
    logic        is_main;               // main space and addr[7:4] clear
    logic        rwait;                 // target needs one extra cycle
    reg_addr_t   raddr_prev;

    assign space   = addr_space_t'(reg_raddr[15:12]);
    assign is_main = (space == ADDR_MAIN) && (reg_raddr[7:4] == 4'd0);

    // ----------------------------------------
    // data and wait mux
    // ----------------------------------------
    always_comb
    begin
        if (space == ADDR_HUB)
            {reg_rdata, rwait} = {rdata_hub, 1'b1};
        else if (is_main)
            {reg_rdata, rwait} = {rdata_regs, 1'b0};
        else
            {reg_rdata, rwait} = {{$bits(reg_data_t){1'b0}}, 1'b0};   // unmapped reads zero
    end

    // ----------------------------------------
    // valid once the address has been held a cycle
    // ----------------------------------------
    always_ff @(posedge sysclk or negedge rst_n)
    begin
        if (!rst_n)
            raddr_prev <= '0;
        else
            raddr_prev <= reg_raddr;
    end

    assign reg_rvalid = ~rwait | (reg_raddr == raddr_prev);

endmodule

/* hdl/board_regs.sv */
// board register block holding status, firmware version and the writable IP address
`timescale 1ns/1ps
`include "reg_bus_macros.svh"

module board_regs
    import reg_bus_pkg::*;
(
    input  logic       sysclk,
    input  logic       rst_n,
    input  logic [3:0] board_id,        // rotary switch
    input  reg_addr_t  reg_raddr,
    input  reg_addr_t  reg_waddr,
    input  reg_data_t  reg_wdata,
    input  logic       reg_wen,
    output reg_data_t  rdata            // space check is done in the read path
);

    reg_data_t ip_address;
    logic      ip_wen;

    // ----------------------------------------
    // write decode on the full address
    // ----------------------------------------
    assign ip_wen = reg_wen && (reg_waddr == {`SPACE_MAIN, 8'h00, `REG_IPADDR});

    always_ff @(posedge sysclk or negedge rst_n)
    begin
        if (!rst_n)
            ip_address <= `IPADDR_RESET;
        else if (ip_wen)
            ip_address <= reg_wdata;    // status and version ignore writes
    end

    // ----------------------------------------
    // read decode on offset
    // ----------------------------------------
    always_comb
    begin
        case (reg_raddr[3:0])
            `REG_STATUS:     rdata = {`STATUS_MAGIC, 12'h000, board_id};
            `REG_FW_VERSION: rdata = `FW_VERSION;
            `REG_IPADDR:     rdata = ip_address;
            default:         rdata = '0;
        endcase
    end

endmodule

/* hdl/hub_mem.sv */
// sixteen quadlet hub memory with a registered read port
`timescale 1ns/1ps
module hub_mem
    import reg_bus_pkg::*;
(
    input  logic      sysclk,
    input  reg_addr_t reg_raddr,
    input  reg_addr_t reg_waddr,
    input  reg_data_t reg_wdata,
    input  logic      reg_wen,
    output reg_data_t rdata             // one cycle after reg_raddr
);

    reg_data_t   mem [0:15];            // indexed by addr[3:0]
    addr_space_t wspace;
    logic        hub_wen;

    assign wspace  = addr_space_t'(reg_waddr[15:12]);
    assign hub_wen = reg_wen && (wspace == ADDR_HUB);

    always_ff @(posedge sysclk)
    begin
        if (hub_wen)
            mem[reg_waddr[3:0]] <= reg_wdata;
        rdata <= mem[reg_raddr[3:0]];   // read wait is one cycle
    end

endmodule

/* hdl/reg_bus_top.sv */
// register bus top joining the FireWire and Ethernet host ports to the board targets
`timescale 1ns/1ps
module reg_bus_top
    import reg_bus_pkg::*;
(
    input  logic       sysclk,
    input  logic       rst_n,
    input  logic [3:0] board_id,
    // FireWire host
    input  logic       fw_req,
    input  logic       fw_we,
    input  reg_addr_t  fw_addr,
    input  reg_data_t  fw_wdata,
    output logic       fw_ack,
    output reg_data_t  fw_rdata,
    // Ethernet host
    input  logic       eth_req,
    input  logic       eth_we,
    input  reg_addr_t  eth_addr,
    input  reg_data_t  eth_wdata,
    output logic       eth_ack,
    output reg_data_t  eth_rdata
);

    // ----------------------------------------
    // per host bus signals
    // ----------------------------------------
    logic      fw_req_read, fw_req_write, fw_grant_read, fw_grant_write, fw_wen;
    logic      eth_req_read, eth_req_write, eth_grant_read, eth_grant_write, eth_wen;
    reg_addr_t fw_raddr, fw_waddr, eth_raddr, eth_waddr;
    reg_data_t fw_wdata_bus, eth_wdata_bus;

    // shared bus
    reg_addr_t reg_raddr, reg_waddr;
    reg_data_t reg_wdata, reg_rdata;
    logic      reg_wen, reg_rvalid;
    reg_data_t rdata_regs, rdata_hub;  // target read data

    host_port fw_port_i (
        .sysclk(sysclk), .rst_n(rst_n),
        .req(fw_req), .we(fw_we), .addr(fw_addr), .wdata(fw_wdata),
        .ack(fw_ack), .rdata(fw_rdata),
        .req_read(fw_req_read), .req_write(fw_req_write),
        .grant_read(fw_grant_read), .grant_write(fw_grant_write),
        .raddr(fw_raddr), .waddr(fw_waddr), .wdata_bus(fw_wdata_bus), .wen(fw_wen),
        .reg_rdata(reg_rdata), .reg_rvalid(reg_rvalid)
    );

    host_port eth_port_i (
        .sysclk(sysclk), .rst_n(rst_n),
        .req(eth_req), .we(eth_we), .addr(eth_addr), .wdata(eth_wdata),
        .ack(eth_ack), .rdata(eth_rdata),
        .req_read(eth_req_read), .req_write(eth_req_write),
        .grant_read(eth_grant_read), .grant_write(eth_grant_write),
        .raddr(eth_raddr), .waddr(eth_waddr), .wdata_bus(eth_wdata_bus), .wen(eth_wen),
        .reg_rdata(reg_rdata), .reg_rvalid(reg_rvalid)
    );

    bus_arbiter arb_i (
        .sysclk(sysclk), .rst_n(rst_n),
        .fw_req_read(fw_req_read), .eth_req_read(eth_req_read),
        .fw_req_write(fw_req_write), .eth_req_write(eth_req_write),
        .fw_grant_read(fw_grant_read), .eth_grant_read(eth_grant_read),
        .fw_grant_write(fw_grant_write), .eth_grant_write(eth_grant_write),
        .fw_raddr(fw_raddr), .eth_raddr(eth_raddr),
        .fw_waddr(fw_waddr), .eth_waddr(eth_waddr),
        .fw_wdata(fw_wdata_bus), .eth_wdata(eth_wdata_bus),
        .fw_wen(fw_wen), .eth_wen(eth_wen),
        .reg_raddr(reg_raddr), .reg_waddr(reg_waddr),
        .reg_wdata(reg_wdata), .reg_wen(reg_wen)
    );

    read_path rd_i (
        .sysclk(sysclk), .rst_n(rst_n), .reg_raddr(reg_raddr),
        .rdata_regs(rdata_regs), .rdata_hub(rdata_hub),
        .reg_rdata(reg_rdata), .reg_rvalid(reg_rvalid)
    );

    board_regs regs_i (
        .sysclk(sysclk), .rst_n(rst_n), .board_id(board_id),
        .reg_raddr(reg_raddr), .reg_waddr(reg_waddr),
        .reg_wdata(reg_wdata), .reg_wen(reg_wen), .rdata(rdata_regs)
    );

    hub_mem hub_i (
        .sysclk(sysclk), .reg_raddr(reg_raddr), .reg_waddr(reg_waddr),
        .reg_wdata(reg_wdata), .reg_wen(reg_wen), .rdata(rdata_hub)
    );

endmodule

/* verif/tb_reg_bus.sv */
// testbench for the register bus top, runs host transactions from the case file and checks them
`timescale 1ns/1ps

module tb_reg_bus;

    localparam int ACK_TIMEOUT = 64;                    // cycles allowed per handshake phase

    typedef struct packed {
        logic        pair;                              // issue together with the next case
        logic        host;                              // 0 FireWire, 1 Ethernet
        logic        we;
        logic [15:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp_data;                          // checked on reads only
    } case_t;

    logic        sysclk;
    logic        rst_n;
    logic [3:0]  board_id;
    logic        fw_req;
    logic        fw_we;
    logic [15:0] fw_addr;
    logic [31:0] fw_wdata;
    logic        fw_ack;
    logic [31:0] fw_rdata;
    logic        eth_req;
    logic        eth_we;
    logic [15:0] eth_addr;
    logic [31:0] eth_wdata;
    logic        eth_ack;
    logic [31:0] eth_rdata;

    case_t       cases[$];
    int unsigned cycle_count = 0;                       // rising edges since time zero
    int          check_count = 0;
    int          error_count = 0;
    int          timeout_count = 0;

    reg_bus_top dut_i (
        .sysclk(sysclk), .rst_n(rst_n), .board_id(board_id),
        .fw_req(fw_req), .fw_we(fw_we), .fw_addr(fw_addr), .fw_wdata(fw_wdata),
        .fw_ack(fw_ack), .fw_rdata(fw_rdata),
        .eth_req(eth_req), .eth_we(eth_we), .eth_addr(eth_addr), .eth_wdata(eth_wdata),
        .eth_ack(eth_ack), .eth_rdata(eth_rdata)
    );

    initial
    begin
        sysclk = 1'b0;
        forever #50 sysclk = ~sysclk;                   // 100 ns period
    end

    always @(posedge sysclk)
        cycle_count <= cycle_count + 1;

    // ----------------------------------------
    // host side helpers
    // ----------------------------------------
    function automatic string host_name(input logic host);
        return host ? "Ethernet" : "FireWire";
    endfunction

    function automatic logic ack_of(input logic host);
        return host ? eth_ack : fw_ack;
    endfunction

    function automatic logic [31:0] rdata_of(input logic host);
        return host ? eth_rdata : fw_rdata;
    endfunction

    // called on a falling edge only
    task automatic drive_host(input logic host, input logic req, input logic we,
                              input logic [15:0] addr, input logic [31:0] wdata);
        if (host)
        begin
            eth_req   = req;
            eth_we    = we;
            eth_addr  = addr;
            eth_wdata = wdata;
        end
        else
        begin
            fw_req   = req;
            fw_we    = we;
            fw_addr  = addr;
            fw_wdata = wdata;
        end
    endtask

    task automatic wait_ack(input logic host, input logic level, output logic seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < ACK_TIMEOUT)
        begin
            @(negedge sysclk);                          // ack is stable mid cycle
            n++;
            seen = (ack_of(host) == level);
        end
        if (!seen)
        begin
            $display("%s host stalled: ack did not go %s within %0d cycles",
                     host_name(host), level ? "high" : "low", ACK_TIMEOUT);
            timeout_count++;
        end
    endtask

    // one full four-phase transaction, ack_cycle is the edge count when ack was seen
    task automatic run_access(input case_t c, output int unsigned ack_cycle);
        logic seen;
        ack_cycle = 0;
        drive_host(c.host, 1'b1, c.we, c.addr, c.wdata);
        wait_ack(c.host, 1'b1, seen);
        if (seen)
        begin
            ack_cycle = cycle_count;
            if (!c.we)
            begin
                check_count++;
                assert (rdata_of(c.host) == c.exp_data)
                else
                begin
                    $display("[ERROR] %0t: %s read of %h returned %h, expected %h", $time,
                             host_name(c.host), c.addr, rdata_of(c.host), c.exp_data);
                    error_count++;
                end
            end
        end
        drive_host(c.host, 1'b0, c.we, c.addr, c.wdata);  // release, ack falls a cycle later
        wait_ack(c.host, 1'b0, seen);
    endtask

    // comment and blank lines do not parse to six fields and are skipped
    task automatic load_cases(output logic ok);
        int          fd;
        int          n;
        string       line;
        int          pair_v;
        int          host_v;
        int          we_v;
        logic [31:0] addr_v;
        logic [31:0] wdata_v;
        logic [31:0] exp_v;
        case_t       c;
        ok = 1'b0;
        fd = $fopen("verif/reg_bus_cases.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the case file verif/reg_bus_cases.txt");
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                n    = $fgets(line, fd);
                n    = $sscanf(line, "%d %d %d %h %h %h",
                               pair_v, host_v, we_v, addr_v, wdata_v, exp_v);
                if (n == 6)
                begin
                    c.pair     = (pair_v != 0);
                    c.host     = (host_v != 0);
                    c.we       = (we_v != 0);
                    c.addr     = addr_v[15:0];
                    c.wdata    = wdata_v;
                    c.exp_data = exp_v;
                    cases.push_back(c);
                end
            end
            $fclose(fd);
            ok = (cases.size() > 0);
        end
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial
    begin : main_seq
        logic        ok;
        int unsigned seed_out;
        int unsigned cyc0;
        int unsigned cyc1;
        int unsigned fw_cyc;
        int unsigned eth_cyc;
        int          i;
        seed_out  = $urandom(32'h03ad_d7bd);            // seeds the idle gap generator
        rst_n     = 1'b0;
        board_id  = 4'hA;
        fw_req    = 1'b0;
        fw_we     = 1'b0;
        fw_addr   = '0;
        fw_wdata  = '0;
        eth_req   = 1'b0;
        eth_we    = 1'b0;
        eth_addr  = '0;
        eth_wdata = '0;
        repeat (10) @(negedge sysclk);
        rst_n = 1'b1;
        @(negedge sysclk);
        check_count++;
        assert (fw_ack == 1'b0 && eth_ack == 1'b0)
        else
        begin
            $display("[ERROR] %0t: ack high after reset, fw_ack %b eth_ack %b",
                     $time, fw_ack, eth_ack);
            error_count++;
        end

        load_cases(ok);
        if (!ok)
        begin
            $display("no transactions were loaded from the case file");
            error_count++;
        end

        i = 0;
        while (ok && i < cases.size() && timeout_count == 0)
        begin
            repeat ($urandom % 4) @(negedge sysclk);    // idle gap of 0 to 3 cycles
            if (cases[i].pair && i + 1 < cases.size())
            begin
                fork                                    // both reqs rise on the same edge
                    run_access(cases[i], cyc0);
                    run_access(cases[i + 1], cyc1);
                join
                fw_cyc  = cases[i].host ? cyc1 : cyc0;
                eth_cyc = cases[i].host ? cyc0 : cyc1;
                if (timeout_count == 0)
                begin
                    check_count++;
                    assert (fw_cyc <= eth_cyc)
                    else
                    begin
                        $display("[ERROR] %0t: FireWire ack at cycle %0d after Ethernet ack at %0d",
                                 $time, fw_cyc, eth_cyc);
                        error_count++;
                    end
                end
                i += 2;
            end
            else
            begin
                run_access(cases[i], cyc0);
                i++;
            end
        end

        $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* verif/reg_bus_cases.txt */
# pair host we addr wdata expect, all values in hex; pair 1 issues this line with the next
# host 0 FireWire, 1 Ethernet; we 1 write, 0 read; expect is checked on reads only
0 0 0 000B 00000000 FFFFFFFF
0 0 0 0000 00000000 5146000A
0 0 0 0004 00000000 00070200
0 1 1 0000 12345678 00000000
0 1 0 0000 00000000 5146000A
0 1 1 000B C0A80A05 00000000
0 0 0 000B 00000000 C0A80A05
0 0 1 2003 11110003 00000000
0 1 1 200C 2222000C 00000000
0 1 0 2003 00000000 11110003
0 0 0 200C 00000000 2222000C
1 0 0 2003 00000000 11110003
0 1 0 200C 00000000 2222000C
1 0 1 2005 55550005 00000000
0 1 1 2006 66660006 00000000
0 1 0 2005 00000000 55550005
0 0 0 2006 00000000 66660006
1 0 0 000B 00000000 C0A80A05
0 1 1 2007 77770007 00000000
0 0 0 2007 00000000 77770007
0 0 0 1000 00000000 00000000
0 1 0 0010 00000000 00000000

/* src.f */
+incdir+include
hdl/reg_bus_pkg.sv
hdl/host_pkg.sv
hdl/host_port.sv
hdl/bus_arbiter.sv
hdl/read_path.sv
hdl/board_regs.sv
hdl/hub_mem.sv
hdl/reg_bus_top.sv
verif/tb_reg_bus.sv

/* Makefile */
# Verilator build and run of the register bus testbench

VERILATOR ?= verilator
TOP       ?= tb_reg_bus
LOG       ?= sim.log
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP LOG FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
